// ==== all.f ====
+incdir+hw
hw/reorder_pkg.sv
hw/dualPortRam.sv
hw/reorderScoreboard.sv
hw/requestIssuer.sv
hw/responseEmitter.sv
hw/readReorderTop.sv
tests/readReorderTb.sv

// ==== hw/dualPortRam.sv ====
/*
  Simple dual-port storage with one write port and one registered read
  port. A read of the address being written in the same cycle returns
  the old contents. The array has no reset.
*/
`timescale 1ns/1ps
`default_nettype none

`include "reorder_defines.svh"

module dualPortRam #(
    parameter int nEntries = `RR_N_ENTRIES,
    parameter int dataBits = `RR_DATA_BITS
) (
    input  wire logic                        clk,
    input  wire logic                        wrEn,
    input  wire logic [$clog2(nEntries)-1:0] wrAddr,
    input  wire logic [dataBits-1:0]         wrData,
    input  wire logic [$clog2(nEntries)-1:0] rdAddr,
    output logic      [dataBits-1:0]         rdData
);

    // Storage array, one word per scoreboard slot
    logic [dataBits-1:0] mem [nEntries];

    // Write and read share one clock
    // The read samples the array before this edge's write takes effect
    always_ff @(posedge clk)
    begin
        if (wrEn)
        begin
            mem[wrAddr] <= wrData;
        end
        rdData <= mem[rdAddr];
    end

endmodule

`default_nettype wire

// ==== hw/readReorderTop.sv ====
/*
  Read reorder unit. Memory must answer every request exactly once, at
  most one answer per cycle, and there is no back-pressure toward memory.
  Responses to the client leave in request order.
*/
`timescale 1ns/1ps
`default_nettype none

`include "reorder_defines.svh"

module readReorderTop (
    input  wire logic                 clk,
    input  wire logic                 resetb,
    // Client requests
    input  wire logic                 reqValid,
    input  wire reorder_pkg::reqT     req,
    output logic                      reqReady,
    // Memory side
    output logic                      memReqValid,
    output reorder_pkg::memReqT       memReq,
    input  wire logic                 memRspValid,
    input  wire reorder_pkg::memRspT  memRsp,
    // Client responses
    input  wire logic                 respStall,
    output logic                      respValid,
    output reorder_pkg::respT         resp
);

    import reorder_pkg::*;

    // Allocation handshake between issuer and scoreboard
    logic notFull;
    tagT  enqIdx;
    logic enqEn;
    metaT enqMeta;

    // Ordered head between scoreboard and emitter
    logic notEmpty;
    dataT first;
    metaT firstMeta;
    logic deqEn;

    requestIssuer issuerInst (
        .clk         (clk),
        .resetb      (resetb),
        .reqValid    (reqValid),
        .req         (req),
        .reqReady    (reqReady),
        .notFull     (notFull),
        .enqIdx      (enqIdx),
        .enqEn       (enqEn),
        .enqMeta     (enqMeta),
        .memReqValid (memReqValid),
        .memReq      (memReq)
    );

    // The memory tag is the slot index, so it addresses the data write directly
    reorderScoreboard #(
        .nEntries (`RR_N_ENTRIES),
        .dataBits (`RR_DATA_BITS)
    ) scoreboardInst (
        .clk       (clk),
        .resetb    (resetb),
        .enqEn     (enqEn),
        .enqMeta   (enqMeta),
        .notFull   (notFull),
        .enqIdx    (enqIdx),
        .dataEn    (memRspValid),
        .dataIdx   (memRsp.tag),
        .data      (memRsp.data),
        .deqEn     (deqEn),
        .notEmpty  (notEmpty),
        .first     (first),
        .firstMeta (firstMeta)
    );

    responseEmitter emitterInst (
        .clk       (clk),
        .resetb    (resetb),
        .notEmpty  (notEmpty),
        .first     (first),
        .firstMeta (firstMeta),
        .deqEn     (deqEn),
        .respStall (respStall),
        .respValid (respValid),
        .resp      (resp)
    );

endmodule

`default_nettype wire

// ==== hw/reorderScoreboard.sv ====
/*
  Scoreboard that sorts out-of-order read data back into allocation order.
  Metadata is stored when a slot is allocated and data when memory answers.
  nEntries must be a power of two and match the tag width of the package.
  There is no ready toward memory, so a data write is always accepted.
*/
`timescale 1ns/1ps
`default_nettype none

`include "reorder_defines.svh"

module reorderScoreboard #(
    parameter int nEntries = `RR_N_ENTRIES,
    parameter int dataBits = `RR_DATA_BITS
) (
    input  wire logic               clk,
    input  wire logic               resetb,
    // Slot allocation
    input  wire logic               enqEn,
    input  wire reorder_pkg::metaT  enqMeta,
    output logic                    notFull,
    output reorder_pkg::tagT        enqIdx,
    // Data arrival from memory, indexed by the tag
    input  wire logic               dataEn,
    input  wire reorder_pkg::tagT   dataIdx,
    input  wire reorder_pkg::dataT  data,
    // Ordered output
    input  wire logic               deqEn,
    output logic                    notEmpty,
    output reorder_pkg::dataT       first,
    output reorder_pkg::metaT       firstMeta
);

    import reorder_pkg::*;

    // Ring pointers
    // Empty when oldest equals newest and full when newest + 1 equals oldest
    tagT newest;
    tagT oldest;
    tagT oldestNext;

    // One bit per slot that says its data has arrived
    logic [nEntries-1:0] dataValid;
    logic [nEntries-1:0] dataValidNext;

    // Metadata saved at allocation time
    metaT metaMem [nEntries];

    // The newest pointer is the slot that the next request will get
    assign enqIdx  = newest;
    assign notFull = (newest + tagT'(1)) != oldest;

    // Advance the oldest pointer as soon as the head is handed out
    assign oldestNext = oldest + tagT'(deqEn);

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            newest <= '0;
            oldest <= '0;
        end
        else
        begin
            if (enqEn)
            begin
                newest <= newest + tagT'(1);
            end
            oldest <= oldestNext;
        end
    end

    // Data storage is read at the next oldest slot so the head is registered
    dualPortRam #(
        .nEntries (nEntries),
        .dataBits (dataBits)
    ) dataRam (
        .clk    (clk),
        .wrEn   (dataEn),
        .wrAddr (dataIdx),
        .wrData (data),
        .rdAddr (oldestNext),
        .rdData (first)
    );

    // Metadata follows the same read timing as the data storage
    always_ff @(posedge clk)
    begin
        if (enqEn)
        begin
            metaMem[newest] <= enqMeta;
        end
        firstMeta <= metaMem[oldestNext];
    end

    // A dequeue retires the head slot and an arrival marks its slot
    always_comb
    begin
        dataValidNext = dataValid;
        if (deqEn)
        begin
            dataValidNext[oldest] = 1'b0;
        end
        if (dataEn)
        begin
            dataValidNext[dataIdx] = 1'b1;
        end
    end

    // notEmpty looks at the registered valid bits of the next head
    // so it lines up with the registered data and metadata reads
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            dataValid <= '0;
            notEmpty  <= 1'b0;
        end
        else
        begin
            dataValid <= dataValidNext;
            notEmpty  <= dataValid[oldestNext];
        end
    end

    // The issuer must never allocate past the kept-empty slot
    assert property (@(posedge clk) disable iff (!resetb) enqEn |-> notFull)
        else $error("reorderScoreboard: enqueue while full");

    // The emitter may only take the head once its data is present
    assert property (@(posedge clk) disable iff (!resetb) deqEn |-> notEmpty)
        else $error("reorderScoreboard: dequeue while head not ready");

    // Memory answers each tag once, so a second write means a lost response
    assert property (@(posedge clk) disable iff (!resetb) dataEn |-> !dataValid[dataIdx])
        else $error("reorderScoreboard: data written to a slot that is already valid");

endmodule

`default_nettype wire

// ==== hw/reorder_defines.svh ====
/*
  Sizing for the read reorder unit. RR_N_ENTRIES must be a power of two
  because slot pointers wrap by overflow. One slot always stays empty,
  so at most RR_N_ENTRIES-1 reads can be outstanding.
*/
`ifndef REORDER_DEFINES_SVH
`define REORDER_DEFINES_SVH

// Scoreboard depth, which also sets the memory tag width
`define RR_N_ENTRIES 16

// Width of a read data word returned by memory
`define RR_DATA_BITS 32

// Client metadata carried around memory untouched
`define RR_META_BITS 8

`define RR_ADDR_BITS 16

`endif

// ==== hw/reorder_pkg.sv ====
/*
  Types shared by the reorder unit. All widths come from the defines
  header, and the tag width is derived from the entry count.
*/
`default_nettype none

`include "reorder_defines.svh"

package reorder_pkg;

    // Plain vectors for the fields that carry a meaning
    typedef logic [`RR_ADDR_BITS-1:0] addrT;
    typedef logic [`RR_DATA_BITS-1:0] dataT;
    typedef logic [`RR_META_BITS-1:0] metaT;

    // A scoreboard slot index, also used as the tag seen by memory
    typedef logic [$clog2(`RR_N_ENTRIES)-1:0] tagT;

    // Read request as the client issues it
    typedef struct packed {
        addrT addr;
        metaT meta;
    } reqT;

    // Request toward memory with the slot index as its tag
    typedef struct packed {
        addrT addr;
        tagT  tag;
    } memReqT;

    // Memory answer, which may arrive in any order
    typedef struct packed {
        tagT  tag;
        dataT data;
    } memRspT;

    // Ordered response joined with the saved metadata
    typedef struct packed {
        metaT meta;
        dataT data;
    } respT;

endpackage

`default_nettype wire

// ==== hw/requestIssuer.sv ====
/*
  Input side of the reorder unit. The client must only pulse reqValid
  while reqReady is high. A request accepted at one edge shows up as a
  one-cycle memReqValid strobe in the following cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module requestIssuer (
    input  wire logic                 clk,
    input  wire logic                 resetb,
    // Client request port
    input  wire logic                 reqValid,
    input  wire reorder_pkg::reqT     req,
    output logic                      reqReady,
    // Allocation port of the scoreboard
    input  wire logic                 notFull,
    input  wire reorder_pkg::tagT     enqIdx,
    output logic                      enqEn,
    output reorder_pkg::metaT         enqMeta,
    // Tagged request toward memory
    output logic                      memReqValid,
    output reorder_pkg::memReqT       memReq
);

    import reorder_pkg::*;

    // Memory request assembled from the client address and the new slot
    memReqT memReqNext;

    // The unit can take a request whenever a slot is free
    assign reqReady = notFull;

    // Allocation happens in the same cycle the request is presented
    // and is gated by notFull so a misbehaving client cannot overrun the ring
    assign enqEn   = reqValid && notFull;
    assign enqMeta = req.meta;

    // The scoreboard hands out its newest pointer as the slot index
    always_comb
    begin
        memReqNext.addr = req.addr;
        memReqNext.tag  = enqIdx;
    end

    // Strobe toward memory follows the allocation by one cycle
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            memReqValid <= 1'b0;
        end
        else
        begin
            memReqValid <= enqEn;
        end
    end

    // Address and tag are only meaningful while memReqValid is high
    always_ff @(posedge clk)
    begin
        if (enqEn)
        begin
            memReq <= memReqNext;
        end
    end

    // The client sees reqReady and must respect it
    // A request while full would be dropped silently by the gating above
    assert property (@(posedge clk) disable iff (!resetb) reqValid |-> notFull)
        else $error("requestIssuer: request presented while scoreboard is full");

endmodule

`default_nettype wire

// ==== hw/responseEmitter.sv ====
/*
  Output side of the reorder unit. The head is taken whenever it is ready
  and the client is not stalling. Responses come out one cycle after the
  dequeue with a one-cycle respValid strobe.
*/
`timescale 1ns/1ps
`default_nettype none

module responseEmitter (
    input  wire logic               clk,
    input  wire logic               resetb,
    // Head of the scoreboard
    input  wire logic               notEmpty,
    input  wire reorder_pkg::dataT  first,
    input  wire reorder_pkg::metaT  firstMeta,
    output logic                    deqEn,
    // Client response port
    input  wire logic               respStall,
    output logic                    respValid,
    output reorder_pkg::respT       resp
);

    import reorder_pkg::*;

    // Response built from the current head
    respT respNext;

    // Hold everything in the scoreboard while the client pushes back
    assign deqEn = notEmpty && !respStall;

    always_comb
    begin
        respNext.meta = firstMeta;
        respNext.data = first;
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            respValid <= 1'b0;
        end
        else
        begin
            respValid <= deqEn;
        end
    end

    // The payload only changes when a head is actually taken
    always_ff @(posedge clk)
    begin
        if (deqEn)
        begin
            resp <= respNext;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Builds the reorder testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module readReorderTb -o simReorder

# The simulator exits non-zero on a fatal error, so the log decides the result
./obj_dir/simReorder > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

// ==== tests/readReorderTb.sv ====
/*
  Testbench for the read reorder unit. Stimulus is read from
  tests/reorder_stim.txt, so the simulator must run from the project root.
  Memory answers pending requests in random order and the client stalls at random.
*/
`timescale 1ns/1ps
`default_nettype none

`include "reorder_defines.svh"

module readReorderTb;

    import reorder_pkg::*;

    localparam int clkPeriod = 40;
    localparam int maxReqs = 64;
    // Requests issued before the phase that fills the ring
    localparam int firstBatch = 6;

    // DUT inputs start at known values
    logic   clk;
    logic   resetb = 1'b0;
    logic   reqValid = 1'b0;
    reqT    req = '0;
    logic   memRspValid = 1'b0;
    memRspT memRsp = '0;
    logic   respStall = 1'b0;
    logic   reqReady;
    logic   memReqValid;
    memReqT memReq;
    logic   respValid;
    respT   resp;

    // Stimulus table, one entry per request line of the file
    addrT stimAddr [maxReqs];
    metaT stimMeta [maxReqs];
    dataT stimData [maxReqs];
    int   nReqs = 0;
    bit   stimLoaded = 1'b0;

    // Expected traffic in issue order
    memReqT expMemReq [$];
    respT   expResp [$];
    // Requests that the memory model has seen and not answered yet
    memReqT pending [$];

    int   seed = 32'h7809871c;
    tagT  expTag = '0;
    int   nIssued = 0;
    int   nResp = 0;
    logic holdStall = 1'b0;
    logic stallSeen = 1'b0;

    readReorderTop i_dut (
        .clk         (clk),
        .resetb      (resetb),
        .reqValid    (reqValid),
        .req         (req),
        .reqReady    (reqReady),
        .memReqValid (memReqValid),
        .memReq      (memReq),
        .memRspValid (memRspValid),
        .memRsp      (memRsp),
        .respStall   (respStall),
        .respValid   (respValid),
        .resp        (resp)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "Run stopped at %0d ns", $time);
    endtask

    task automatic compareFlag(input string name, input logic got, input logic expected);
        if (got !== expected)
        begin
            $display("Mismatch at %0d ns: %s expected %b, got %b", $time, name, expected, got);
            abortRun("Control signal has the wrong level");
        end
    endtask

    task automatic compareMemReq(input memReqT got, input memReqT expected);
        if (got !== expected)
        begin
            $display("Mismatch at %0d ns: memReq expected addr %h tag %h, got addr %h tag %h",
                     $time, expected.addr, expected.tag, got.addr, got.tag);
            abortRun("Memory request does not match the client request");
        end
    endtask

    task automatic compareResp(input respT got, input respT expected);
        if (got !== expected)
        begin
            $display("Mismatch at %0d ns: resp expected meta %h data %h, got meta %h data %h",
                     $time, expected.meta, expected.data, got.meta, got.data);
            abortRun("Response out of order or with wrong contents");
        end
    endtask

    task automatic loadStimulus();
        int    fd;
        int    nFields;
        string line;
        addrT  a;
        metaT  m;
        dataT  d;
        fd = $fopen("tests/reorder_stim.txt", "r");
        if (fd == 0)
            abortRun("Cannot open the stimulus file tests/reorder_stim.txt");
        while ($fgets(line, fd) > 0)
        begin
            // Lines starting with # describe the columns
            if (line.getc(0) == "#")
                continue;
            nFields = $sscanf(line, "%h %h %h", a, m, d);
            if (nFields != 3)
                continue;
            if (nReqs == maxReqs)
                abortRun("Stimulus file holds more requests than the table");
            stimAddr[nReqs] = a;
            stimMeta[nReqs] = m;
            stimData[nReqs] = d;
            nReqs = nReqs + 1;
        end
        $fclose(fd);
        stimLoaded = 1'b1;
    endtask

    // Memory contents come straight from the stimulus table
    task automatic findData(input addrT a, output dataT d);
        int k;
        bit found;
        found = 1'b0;
        d = '0;
        for (k = 0; k < nReqs; k++)
        begin
            if (stimAddr[k] == a)
            begin
                d = stimData[k];
                found = 1'b1;
            end
        end
        if (!found)
            abortRun("Memory request for an address that is not in the stimulus");
    endtask

    // One request per call, never back to back
    // The cycle before the drive edge has no enqueue, so reqReady can only rise at that edge
    task automatic issueRequest(input int i);
        memReqT mr;
        respT   rs;
        @(posedge clk);
        while (!reqReady)
            @(posedge clk);
        reqValid <= 1'b1;
        req.addr <= stimAddr[i];
        req.meta <= stimMeta[i];
        // Tags count up from zero and wrap with the ring
        mr.addr = stimAddr[i];
        mr.tag  = expTag;
        rs.meta = stimMeta[i];
        rs.data = stimData[i];
        expMemReq.push_back(mr);
        expResp.push_back(rs);
        expTag  = expTag + tagT'(1);
        nIssued = nIssued + 1;
        // The DUT takes the request at this edge
        @(posedge clk);
        reqValid <= 1'b0;
        // The memory strobe must show up in the very next cycle
        @(posedge clk);
        compareFlag("memReqValid", memReqValid, 1'b1);
    endtask

    task automatic waitDrain();
        wait (nResp == nIssued);
        @(posedge clk);
    endtask

    // Memory model that records requests and answers a random pending one
    task automatic serveMemory();
        memReqT expected;
        memReqT pick;
        dataT   word;
        int     idx;
        if (memReqValid)
        begin
            if (expMemReq.size() == 0)
                abortRun("Memory request seen with no client request outstanding");
            expected = expMemReq.pop_front();
            compareMemReq(memReq, expected);
            pending.push_back(memReq);
        end
        // Skipping about half the cycles lets several answers pile up for reordering
        if (pending.size() > 0 && ($random(seed) & 1) == 0)
        begin
            idx  = int'($unsigned($random(seed)) % pending.size());
            pick = pending[idx];
            pending.delete(idx);
            findData(pick.addr, word);
            memRsp.tag  <= pick.tag;
            memRsp.data <= word;
            memRspValid <= 1'b1;
        end
        else
            memRspValid <= 1'b0;
    endtask

    // Memory and client stall share one process so the random sequence is fixed
    always @(posedge clk)
    begin
        if (!resetb)
        begin
            memRspValid <= 1'b0;
            respStall   <= 1'b0;
        end
        else
        begin
            serveMemory();
            respStall <= holdStall || (($random(seed) & 3) == 0);
        end
    end

    // Response checker
    always @(posedge clk)
    begin : checkResponses
        respT expected;
        if (resetb && respValid)
        begin
            // A response now comes from a dequeue in a cycle where stall was low
            if (stallSeen)
                compareFlag("respValid", respValid, 1'b0);
            if (expResp.size() == 0)
                abortRun("Response seen with no request outstanding");
            expected = expResp.pop_front();
            compareResp(resp, expected);
            nResp = nResp + 1;
        end
        stallSeen = respStall;
    end

    // Watchdog allows 200 cycles per request plus a margin
    initial
    begin : watchdog
        wait (stimLoaded);
        repeat (200 * nReqs + 100) @(posedge clk);
        abortRun("Watchdog expired before every request received its response");
    end

    initial
    begin : mainSequence
        int i;
        loadStimulus();
        if (nReqs < firstBatch + `RR_N_ENTRIES)
            abortRun("Stimulus file holds too few requests for all test phases");
        repeat (3) @(posedge clk);
        resetb <= 1'b1;
        @(posedge clk);
        // Idle levels right after reset
        compareFlag("memReqValid", memReqValid, 1'b0);
        compareFlag("respValid", respValid, 1'b0);
        compareFlag("reqReady", reqReady, 1'b1);

        // Ordinary traffic with random stalls
        for (i = 0; i < firstBatch; i++)
            issueRequest(i);
        waitDrain();

        // Fill every usable slot while the client stalls
        holdStall <= 1'b1;
        repeat (2) @(posedge clk);
        for (i = firstBatch; i < firstBatch + `RR_N_ENTRIES - 1; i++)
            issueRequest(i);
        compareFlag("reqReady", reqReady, 1'b0);
        repeat (60) @(posedge clk);
        compareFlag("reqReady", reqReady, 1'b0);
        holdStall <= 1'b0;
        waitDrain();
        compareFlag("reqReady", reqReady, 1'b1);

        // Rest of the file with random stalls again
        for (i = firstBatch + `RR_N_ENTRIES - 1; i < nReqs; i++)
            issueRequest(i);
        waitDrain();
        repeat (10) @(posedge clk);

        if (expMemReq.size() != 0 || pending.size() != 0 || expResp.size() != 0)
            abortRun("Traffic was left outstanding at the end of the run");
        else
        begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tests/reorder_stim.txt ====
# address(hex) metadata(hex) data(hex), one read request per line
# data is what memory returns for that address; addresses are unique
0100 a1 3c5e0f12
0104 b2 9a0d44e1
0108 c3 00ff00ff
010c d4 12345678
0110 e5 deadbeef
0114 f6 cafef00d
2000 01 0badc0de
2004 02 11112222
2008 03 33334444
200c 04 55556666
2010 05 77778888
2014 06 9999aaaa
2018 07 bbbbcccc
201c 08 ddddeeee
2020 09 fedcba98
2024 0a 76543210
2028 0b a5a55a5a
202c 0c 5a5aa5a5
2030 0d 0f0f0f0f
2034 0e f0f0f0f0
2038 0f 13579bdf
4000 7e 2468ace0
4040 6d 8badf00d
4080 5c 1badb002
40c0 4b c001d00d
4100 3a 00000001
4140 29 80000000
4180 18 ffffffff
